// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= logic_scope_tb
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qx "No errors"

clean:
	rm -rf $(BUILD)

// ==== design/capture_engine.sv ====
`timescale 1ns/1ps

module capture_engine (
    input  logic                         clk,
    input  logic                         arstn_sync,
    input  logic                         sample_en,
    input  logic                         arm,
    input  logic [la_pkg::num_waves-1:0] data,
    input  la_pkg::trig_mode_t           trig_mode [la_pkg::num_waves],
    input  la_pkg::trig_pos_t            trig_pos,
    output la_pkg::wave_snap_t           snap,
    output logic [la_pkg::step_w-1:0]    trig_index,
    output logic                         cap_done,
    output logic                         cap_busy
);

    la_pkg::wave_snap_t           cap_buf;
    logic [la_pkg::num_waves-1:0] match;
    logic                         triggered;
    logic [la_pkg::step_w-1:0]    post_cnt;   // samples still to take after the trigger
    la_pkg::trig_pos_t            pos_lat;
    logic                         finish;

    function automatic logic [la_pkg::step_w-1:0] pos_offset(la_pkg::trig_pos_t pos);
        case (pos)
            la_pkg::pos_mid:   return la_pkg::pos_ofs_mid;
            la_pkg::pos_right: return la_pkg::pos_ofs_right;
            default:           return la_pkg::pos_ofs_left;
        endcase
    endfunction

    // incoming bit against the newest stored bit of the same channel
    always_comb begin
        for (int w = 0; w < la_pkg::num_waves; w++) begin
            case (trig_mode[w])
                la_pkg::trig_rising:
                    match[w] = data[w] & ~cap_buf[w][la_pkg::wave_steps-1];
                la_pkg::trig_falling:
                    match[w] = ~data[w] & cap_buf[w][la_pkg::wave_steps-1];
                la_pkg::trig_either:
                    match[w] = data[w] ^ cap_buf[w][la_pkg::wave_steps-1];
                la_pkg::trig_low:  match[w] = ~data[w];
                la_pkg::trig_high: match[w] = data[w];
                default:           match[w] = 1'b1;
            endcase
        end
    end

    assign finish = cap_busy & triggered & (post_cnt == '0);

    always_ff @(posedge clk or negedge arstn_sync) begin
        if (!arstn_sync) begin
            for (int w = 0; w < la_pkg::num_waves; w++) begin
                cap_buf[w] <= '0;
                snap[w]    <= '0;
            end
            triggered  <= 1'b0;
            post_cnt   <= '0;
            pos_lat    <= la_pkg::pos_left;
            trig_index <= '0;
            cap_done   <= 1'b0;
            cap_busy   <= 1'b0;
        end else begin
            cap_done <= 1'b0;

            // rolling buffer, newest sample enters at the top
            if (sample_en) begin
                for (int w = 0; w < la_pkg::num_waves; w++) begin
                    cap_buf[w] <= {data[w], cap_buf[w][la_pkg::wave_steps-1:1]};
                end
            end

            if (arm) begin   // also restarts a running capture
                cap_busy  <= 1'b1;
                triggered <= 1'b0;
                post_cnt  <= la_pkg::wave_steps - 7'd1 - pos_offset(trig_pos);
                pos_lat   <= trig_pos;
            end else if (finish) begin
                // buffer already holds the last post-trigger sample
                snap       <= cap_buf;
                trig_index <= pos_offset(pos_lat);
                cap_done   <= 1'b1;
                cap_busy   <= 1'b0;
            end else if (cap_busy && sample_en) begin
                if (triggered) begin
                    post_cnt <= post_cnt - 7'd1;
                end else if (&match) begin
                    triggered <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/la_pkg.sv ====
package la_pkg;

    // capture sizes
    localparam int num_waves = 5;
    localparam int step_w    = 7;

    localparam logic [step_w-1:0] wave_steps   = 7'd120;
    localparam logic [step_w-1:0] screen_steps = 7'd60;
    localparam logic [step_w-1:0] step_move    = 7'd5;

    // snapshot index of the trigger sample per position
    localparam logic [step_w-1:0] pos_ofs_left  = 7'd3;
    localparam logic [step_w-1:0] pos_ofs_mid   = 7'd60;
    localparam logic [step_w-1:0] pos_ofs_right = 7'd115;

    // display is mounted sideways, waves run along y
    localparam int coord_w = 16;
    localparam int color_w = 16;

    localparam logic [coord_w-1:0] top_ofs      = 16'd10;
    localparam logic [coord_w-1:0] left_ofs     = 16'd60;
    localparam logic [coord_w-1:0] wave_height  = 16'd17;
    localparam logic [coord_w-1:0] step_width   = 16'd5;
    localparam logic [coord_w-1:0] wave_pitch   = 16'd38;
    localparam logic [coord_w-1:0] plot_x_low   = 16'd51;
    localparam logic [coord_w-1:0] screen_x_max = 16'd239;
    localparam logic [coord_w-1:0] screen_y_max = 16'd319;
    localparam logic [coord_w-1:0] plot_x_high  = screen_x_max - top_ofs;  // base of wave 0

    // rgb565
    localparam logic [color_w-1:0] col_black = 16'h0000;
    localparam logic [color_w-1:0] col_white = 16'hffff;
    localparam logic [color_w-1:0] col_blue  = 16'h001f;

    typedef enum logic [2:0] {
        trig_dontcare = 3'd0,
        trig_rising   = 3'd1,
        trig_falling  = 3'd2,
        trig_either   = 3'd3,
        trig_low      = 3'd4,
        trig_high     = 3'd5
    } trig_mode_t;

    typedef enum logic [1:0] {
        pos_left  = 2'd0,
        pos_mid   = 2'd1,
        pos_right = 2'd2
    } trig_pos_t;

    // divider rates tick once every n clocks
    typedef enum logic [2:0] {
        rate_ext_rise = 3'd0,
        rate_ext_fall = 3'd1,
        rate_div_2k   = 3'd2,
        rate_div_256  = 3'd3,
        rate_div_64   = 3'd4,
        rate_div_16   = 3'd5,
        rate_div_4    = 3'd6,
        rate_div_1    = 3'd7
    } rate_sel_t;

    typedef logic [wave_steps-1:0] wave_snap_t [num_waves];

endpackage

// ==== design/logic_scope_top.sv ====
`timescale 1ns/1ps

module logic_scope_top (
    input  logic                       clk,
    input  logic                       arstn_sync,
    input  logic [5:0]                 logic_in,   // bit 0 is the sample clock
    input  la_pkg::rate_sel_t          rate,
    input  la_pkg::trig_mode_t         trig_mode [la_pkg::num_waves],
    input  la_pkg::trig_pos_t          trig_pos,
    input  logic                       arm,
    input  logic                       scroll_left,
    input  logic                       scroll_right,
    input  logic                       draw_done,
    output logic                       draw,
    output logic [la_pkg::color_w-1:0] draw_color,
    output logic [la_pkg::coord_w-1:0] draw_x0,
    output logic [la_pkg::coord_w-1:0] draw_y0,
    output logic [la_pkg::coord_w-1:0] draw_x1,
    output logic [la_pkg::coord_w-1:0] draw_y1,
    output logic                       render_busy,
    output logic                       cap_busy
);

    logic                      sample_en;
    la_pkg::wave_snap_t        snap;
    logic [la_pkg::step_w-1:0] trig_index;
    logic                      cap_done;
    logic [la_pkg::step_w-1:0] view_start;
    logic                      view_moved;

    sample_tick_gen u_sample_tick_gen (
        .clk        (clk),
        .arstn_sync (arstn_sync),
        .rate       (rate),
        .ext_clk    (logic_in[0]),
        .sample_en  (sample_en)
    );

    capture_engine u_capture_engine (
        .clk        (clk),
        .arstn_sync (arstn_sync),
        .sample_en  (sample_en),
        .arm        (arm),
        .data       (logic_in[5:1]),
        .trig_mode  (trig_mode),
        .trig_pos   (trig_pos),
        .snap       (snap),
        .trig_index (trig_index),
        .cap_done   (cap_done),
        .cap_busy   (cap_busy)
    );

    view_scroll u_view_scroll (
        .clk          (clk),
        .arstn_sync   (arstn_sync),
        .scroll_left  (scroll_left),
        .scroll_right (scroll_right),
        .cap_done     (cap_done),
        .view_start   (view_start),
        .view_moved   (view_moved)
    );

    wave_renderer u_wave_renderer (
        .clk         (clk),
        .arstn_sync  (arstn_sync),
        .cap_done    (cap_done),
        .view_moved  (view_moved),
        .draw_done   (draw_done),
        .snap        (snap),
        .trig_index  (trig_index),
        .view_start  (view_start),
        .draw        (draw),
        .render_busy (render_busy),
        .draw_color  (draw_color),
        .draw_x0     (draw_x0),
        .draw_y0     (draw_y0),
        .draw_x1     (draw_x1),
        .draw_y1     (draw_y1)
    );

endmodule

// ==== design/sample_tick_gen.sv ====
`timescale 1ns/1ps

module sample_tick_gen (
    input  logic              clk,
    input  logic              arstn_sync,
    input  la_pkg::rate_sel_t rate,
    input  logic              ext_clk,
    output logic              sample_en
);

    logic [14:0] div_cnt;
    logic [14:0] div_mask;
    logic        ext_meta;
    logic        ext_sync;
    logic        ext_prev;
    logic        tick;

    always_comb begin
        case (rate)
            la_pkg::rate_div_2k:  div_mask = 15'h07ff;
            la_pkg::rate_div_256: div_mask = 15'h00ff;
            la_pkg::rate_div_64:  div_mask = 15'h003f;
            la_pkg::rate_div_16:  div_mask = 15'h000f;
            la_pkg::rate_div_4:   div_mask = 15'h0003;
            default:              div_mask = 15'h0000;  // every clock
        endcase

        case (rate)
            la_pkg::rate_ext_rise: tick = ext_sync & ~ext_prev;
            la_pkg::rate_ext_fall: tick = ext_prev & ~ext_sync;
            default:               tick = (div_cnt & div_mask) == div_mask;
        endcase
    end

    always_ff @(posedge clk or negedge arstn_sync) begin
        if (!arstn_sync) begin
            div_cnt   <= '0;
            ext_meta  <= 1'b0;
            ext_sync  <= 1'b0;
            ext_prev  <= 1'b0;
            sample_en <= 1'b0;
        end else begin
            div_cnt   <= div_cnt + 15'd1;
            ext_meta  <= ext_clk;   // async pin
            ext_sync  <= ext_meta;
            ext_prev  <= ext_sync;
            sample_en <= tick;
        end
    end

endmodule

// ==== design/view_scroll.sv ====
`timescale 1ns/1ps

module view_scroll (
    input  logic                      clk,
    input  logic                      arstn_sync,
    input  logic                      scroll_left,
    input  logic                      scroll_right,
    input  logic                      cap_done,
    output logic [la_pkg::step_w-1:0] view_start,
    output logic                      view_moved
);

    logic left_q;
    logic right_q;

    always_ff @(posedge clk or negedge arstn_sync) begin
        if (!arstn_sync) begin
            left_q     <= 1'b0;
            right_q    <= 1'b0;
            view_start <= '0;
            view_moved <= 1'b0;
        end else begin
            left_q     <= scroll_left;
            right_q    <= scroll_right;
            view_moved <= 1'b0;

            // a new capture is redrawn anyway, so no move pulse here
            if (cap_done) begin
                view_start <= '0;
            end else if (scroll_left && !left_q && view_start >= la_pkg::step_move) begin
                view_start <= view_start - la_pkg::step_move;
                view_moved <= 1'b1;
            end else if (scroll_right && !right_q &&
                         view_start < la_pkg::wave_steps - la_pkg::screen_steps) begin
                view_start <= view_start + la_pkg::step_move;
                view_moved <= 1'b1;
            end
        end
    end

endmodule

// ==== design/wave_renderer.sv ====
`timescale 1ns/1ps

module wave_renderer (
    input  logic                       clk,
    input  logic                       arstn_sync,
    input  logic                       cap_done,
    input  logic                       view_moved,
    input  logic                       draw_done,
    input  la_pkg::wave_snap_t         snap,
    input  logic [la_pkg::step_w-1:0]  trig_index,
    input  logic [la_pkg::step_w-1:0]  view_start,
    output logic                       draw,
    output logic                       render_busy,
    output logic [la_pkg::color_w-1:0] draw_color,
    output logic [la_pkg::coord_w-1:0] draw_x0,
    output logic [la_pkg::coord_w-1:0] draw_y0,
    output logic [la_pkg::coord_w-1:0] draw_x1,
    output logic [la_pkg::coord_w-1:0] draw_y1
);

    typedef enum logic [2:0] {
        s_idle,
        s_clear,
        s_marker,
        s_edge,
        s_level,
        s_next_step,
        s_next_wave
    } state_t;

    state_t                     state;
    logic [2:0]                 wave;
    logic [la_pkg::step_w-1:0]  step;
    logic [la_pkg::step_w-1:0]  step_end;   // last step drawn, inclusive
    logic [la_pkg::step_w-1:0]  view_lat;
    logic [la_pkg::step_w-1:0]  win_end;
    logic [la_pkg::coord_w-1:0] xbase;
    logic [la_pkg::coord_w-1:0] ypos;
    logic [la_pkg::coord_w-1:0] level_x;
    logic                       pending;
    logic                       cur_bit;
    logic                       prev_bit;
    logic                       bit_change;
    logic                       cmd_state;
    logic                       accepted;

    assign cur_bit    = snap[wave][step];
    assign prev_bit   = snap[wave][(step == '0) ? step : step - 7'd1];
    assign bit_change = (step > view_lat) && (cur_bit != prev_bit);
    assign level_x    = cur_bit ? xbase : xbase - la_pkg::wave_height;
    assign win_end    = (view_start + la_pkg::screen_steps < la_pkg::wave_steps) ?
                        view_start + la_pkg::screen_steps : la_pkg::wave_steps - 7'd1;

    assign cmd_state = (state == s_clear) || (state == s_marker) ||
                       (state == s_edge) || (state == s_level);
    assign accepted  = draw & draw_done;

    // command fields follow the state, which only moves on draw_done
    always_comb begin
        draw_color = la_pkg::col_white;
        draw_x0    = xbase - la_pkg::wave_height;   // vertical segment
        draw_y0    = ypos;
        draw_x1    = xbase;
        draw_y1    = ypos;
        case (state)
            s_clear: begin
                draw_color = la_pkg::col_black;
                draw_x0    = la_pkg::plot_x_low;
                draw_y0    = la_pkg::left_ofs;
                draw_x1    = la_pkg::plot_x_high;
                draw_y1    = la_pkg::screen_y_max;
            end
            s_marker: begin
                draw_color = la_pkg::col_blue;
                draw_x0    = la_pkg::plot_x_low;
            end
            s_level: begin
                draw_x0 = level_x;
                draw_x1 = level_x;
                draw_y1 = ypos + la_pkg::step_width;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arstn_sync) begin
        if (!arstn_sync) begin
            state       <= s_idle;
            draw        <= 1'b0;
            render_busy <= 1'b0;
            pending     <= 1'b0;
            wave        <= '0;
            step        <= '0;
            step_end    <= '0;
            view_lat    <= '0;
            xbase       <= '0;
            ypos        <= '0;
        end else begin
            draw <= cmd_state & ~accepted;   // low for a cycle between commands

            // at most one redraw queued behind the current one
            if (state != s_idle && (cap_done || view_moved)) begin
                pending <= 1'b1;
            end

            case (state)
                s_idle: begin
                    if (cap_done || view_moved || pending) begin
                        pending     <= 1'b0;
                        render_busy <= 1'b1;
                        state       <= s_clear;
                    end
                end
                s_clear: begin
                    if (accepted) begin
                        wave     <= '0;
                        step     <= view_start;
                        view_lat <= view_start;
                        step_end <= win_end;
                        xbase    <= la_pkg::plot_x_high;
                        ypos     <= la_pkg::left_ofs;
                        state    <= s_next_step;
                    end
                end
                s_marker: begin
                    if (accepted) begin
                        state <= bit_change ? s_edge : s_level;
                    end
                end
                s_edge: begin
                    if (accepted) begin
                        state <= s_level;
                    end
                end
                s_level: begin
                    if (accepted) begin
                        if (step != step_end) begin
                            step  <= step + 7'd1;
                            ypos  <= ypos + la_pkg::step_width;
                            state <= s_next_step;
                        end else if (wave == 3'(la_pkg::num_waves - 1)) begin
                            render_busy <= 1'b0;
                            state       <= s_idle;
                        end else begin
                            state <= s_next_wave;
                        end
                    end
                end
                s_next_step: begin
                    if (wave == '0 && step == trig_index) begin
                        state <= s_marker;
                    end else if (bit_change) begin
                        state <= s_edge;
                    end else begin
                        state <= s_level;
                    end
                end
                s_next_wave: begin
                    wave  <= wave + 3'd1;
                    xbase <= xbase - la_pkg::wave_pitch;
                    ypos  <= la_pkg::left_ofs;
                    step  <= view_lat;
                    state <= s_next_step;
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// ==== sim.f ====
design/la_pkg.sv
design/sample_tick_gen.sv
design/capture_engine.sv
design/view_scroll.sv
design/wave_renderer.sv
design/logic_scope_top.sv
testbench/tb_clock_gen.sv
testbench/logic_scope_properties.sv
testbench/logic_scope_tb.sv

// ==== testbench/logic_scope_properties.sv ====
`timescale 1ns/1ps

module logic_scope_properties (
    input logic        clk,
    input logic        arstn_sync,
    input logic        draw,
    input logic        draw_done,
    input logic [15:0] draw_color,
    input logic [15:0] draw_x0,
    input logic [15:0] draw_y0,
    input logic [15:0] draw_x1,
    input logic [15:0] draw_y1,
    input logic        cap_done
);

    draw_drops: assert property (@(posedge clk) disable iff (!arstn_sync)
        draw && draw_done |=> !draw)
        else $error("draw still high after draw_done");

    // fields hold until the display takes the command
    fields_hold: assert property (@(posedge clk) disable iff (!arstn_sync)
        draw && !draw_done |=> draw && $stable(draw_color) && $stable(draw_x0) &&
        $stable(draw_y0) && $stable(draw_x1) && $stable(draw_y1))
        else $error("draw command changed before draw_done");

    done_pulse: assert property (@(posedge clk) disable iff (!arstn_sync)
        cap_done |=> !cap_done)
        else $error("cap_done longer than one cycle");

endmodule

// ==== testbench/logic_scope_tb.sv ====
`timescale 1ns/1ps

module logic_scope_tb;

    logic               clk;
    logic               arstn_sync;
    logic [5:0]         logic_in;
    la_pkg::rate_sel_t  rate;
    la_pkg::trig_mode_t trig_mode [la_pkg::num_waves];
    la_pkg::trig_pos_t  trig_pos;
    logic               arm;
    logic               scroll_left;
    logic               scroll_right;
    logic               draw_done;
    logic               draw;
    logic [15:0]        draw_color;
    logic [15:0]        draw_x0;
    logic [15:0]        draw_y0;
    logic [15:0]        draw_x1;
    logic [15:0]        draw_y1;
    logic               render_busy;
    logic               cap_busy;

    logic [79:0] exp_q[$];      // {color, x0, y0, x1, y1}
    int          exp_counts[$]; // commands per redraw
    int          cmd_cnt = 0;
    int          cycles = 0;
    int          limit = 1000;
    bit          mbuf  [5][120];
    bit          msnap [5][120];
    int          mtrig;
    int          view;

    tb_clock_gen u_clock_gen (.clk(clk), .arstn_sync(arstn_sync));

    logic_scope_top u_logic_scope_top (
        .clk(clk), .arstn_sync(arstn_sync), .logic_in(logic_in), .rate(rate),
        .trig_mode(trig_mode), .trig_pos(trig_pos), .arm(arm),
        .scroll_left(scroll_left), .scroll_right(scroll_right), .draw_done(draw_done),
        .draw(draw), .draw_color(draw_color), .draw_x0(draw_x0), .draw_y0(draw_y0),
        .draw_x1(draw_x1), .draw_y1(draw_y1), .render_busy(render_busy), .cap_busy(cap_busy)
    );

    bind wave_renderer logic_scope_properties u_props (
        .clk(clk), .arstn_sync(arstn_sync), .draw(draw), .draw_done(draw_done),
        .draw_color(draw_color), .draw_x0(draw_x0), .draw_y0(draw_y0),
        .draw_x1(draw_x1), .draw_y1(draw_y1), .cap_done(cap_done)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    function automatic bit trig_ok(input int mode, input bit inb, input bit last);
        case (mode)
            1: return inb && !last;
            2: return !inb && last;
            3: return inb != last;
            4: return !inb;
            5: return inb;
            default: return 1'b1;
        endcase
    endfunction

    task automatic push_cmd(input logic [15:0] c, input logic [15:0] x0, input logic [15:0] y0,
                            input logic [15:0] x1, input logic [15:0] y1);
        exp_q.push_back({c, x0, y0, x1, y1});
    endtask

    // expected command list of one redraw
    task automatic build_redraw(input int start);
        int          last;
        int          n0;
        logic [15:0] base;
        logic [15:0] y;
        logic [15:0] x;
        n0   = exp_q.size();
        last = (start + 60 < 120) ? start + 60 : 119;
        push_cmd(la_pkg::col_black, la_pkg::plot_x_low, la_pkg::left_ofs,
                 la_pkg::screen_x_max - la_pkg::top_ofs, la_pkg::screen_y_max);
        for (int w = 0; w < 5; w++) begin
            base = la_pkg::screen_x_max - la_pkg::top_ofs - 16'(w) * la_pkg::wave_pitch;
            y    = la_pkg::left_ofs;
            for (int s = start; s <= last; s++) begin
                if (w == 0 && s == mtrig) begin
                    push_cmd(la_pkg::col_blue, la_pkg::plot_x_low, y, base, y);
                end
                if (s > start && msnap[w][s] != msnap[w][s-1]) begin
                    push_cmd(la_pkg::col_white, base - la_pkg::wave_height, y, base, y);
                end
                x = msnap[w][s] ? base : base - la_pkg::wave_height;
                push_cmd(la_pkg::col_white, x, y, x, y + la_pkg::step_width);
                y = y + la_pkg::step_width;
            end
        end
        exp_counts.push_back(exp_q.size() - n0);
        limit += 20 * (exp_q.size() - n0);
    endtask

    task automatic wait_idle();
        do @(negedge clk); while (exp_q.size() != 0 || render_busy);
        repeat (3) @(posedge clk);
    endtask

    task automatic drive_sample(input int v, input bit fall);
        @(posedge clk);
        #1 logic_in[5:1] = 5'(v);
        logic_in[0] = !fall;
        repeat (8) @(posedge clk);
        #1 logic_in[0] = fall;
        repeat (8) @(posedge clk);
    endtask

    task automatic pulse_scroll(input bit right);
        @(posedge clk);
        #1;
        if (right) begin
            scroll_right = 1'b1;
        end else begin
            scroll_left = 1'b1;
        end
        repeat (2) @(posedge clk);
        #1 scroll_right = 1'b0;
        scroll_left = 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // display side, answers each command after a random delay
    initial begin
        int d;
        forever begin
            @(negedge clk);
            if (draw) begin
                if (exp_q.size() == 0) begin
                    abort_run("display received a command that was not expected");
                end
                check("draw_color", draw_color, exp_q[0][79:64]);
                check("draw_x0", draw_x0, exp_q[0][63:48]);
                check("draw_y0", draw_y0, exp_q[0][47:32]);
                check("draw_x1", draw_x1, exp_q[0][31:16]);
                check("draw_y1", draw_y1, exp_q[0][15:0]);
                void'(exp_q.pop_front());
                cmd_cnt++;
                d = $urandom % 6;
                repeat (d + 1) @(posedge clk);
                #1 draw_done = 1'b1;
                @(posedge clk);
                #1 draw_done = 1'b0;
            end
        end
    end

    // command count per redraw, checked as render_busy falls
    initial begin
        logic busy_q;
        busy_q = 1'b0;
        forever begin
            @(negedge clk);
            if (busy_q && !render_busy) begin
                if (exp_counts.size() == 0) abort_run("redraw finished with none expected");
                check("command count", 16'(cmd_cnt), 16'(exp_counts.pop_front()));
                cmd_cnt = 0;
            end
            busy_q = render_busy;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            abort_run($sformatf("timeout, DUT did not finish in %0d cycles", cycles));
        end
    end

    initial begin
        int    fd;
        int    r;
        int    m [5];
        int    p;
        int    n;
        int    v;
        int    act;
        int    post;
        bit    busy;
        bit    hit;
        bit    all;
        string line;
        void'($urandom(32'hace99cdf));
        logic_in     = '0;
        rate         = la_pkg::rate_ext_rise;
        trig_pos     = la_pkg::pos_left;
        arm          = 1'b0;
        scroll_left  = 1'b0;
        scroll_right = 1'b0;
        draw_done    = 1'b0;
        for (int w = 0; w < 5; w++) trig_mode[w] = la_pkg::trig_dontcare;
        fd = $fopen("testbench/scope_vectors.txt", "r");
        if (fd == 0) abort_run("cannot open testbench/scope_vectors.txt");
        void'($fgets(line, fd));   // two column description lines
        void'($fgets(line, fd));
        @(posedge arstn_sync);
        repeat (2) @(posedge clk);
        view = 0;

        while ($fscanf(fd, "%d", r) == 1) begin
            for (int w = 0; w < 5; w++) void'($fscanf(fd, "%d", m[w]));
            void'($fscanf(fd, "%d %d", p, n));
            limit += 200 * n;
            @(posedge clk);
            #1 rate = la_pkg::rate_sel_t'(r);
            for (int w = 0; w < 5; w++) trig_mode[w] = la_pkg::trig_mode_t'(m[w]);
            trig_pos = la_pkg::trig_pos_t'(p);
            logic_in[0] = (r == 1);   // idle level, its edge is not the sample edge
            repeat (6) @(posedge clk);
            #1 arm = 1'b1;
            @(posedge clk);
            #1 arm = 1'b0;
            mtrig = (p == 1) ? 60 : (p == 2) ? 115 : 3;
            post  = 119 - mtrig;
            busy  = 1'b1;
            hit   = 1'b0;
            for (int i = 0; i < n; i++) begin
                @(negedge clk);
                check("cap_busy", 16'(cap_busy), 16'(busy));
                void'($fscanf(fd, "%h", v));
                if (busy && !hit) begin
                    all = 1'b1;
                    for (int w = 0; w < 5; w++) all &= trig_ok(m[w], v[w], mbuf[w][119]);
                    hit = all;
                end else if (busy) begin
                    post--;
                end
                for (int w = 0; w < 5; w++) begin
                    for (int k = 0; k < 119; k++) mbuf[w][k] = mbuf[w][k+1];
                    mbuf[w][119] = v[w];
                end
                if (busy && hit && post == 0) begin
                    busy  = 1'b0;
                    msnap = mbuf;
                    view  = 0;   // new capture resets the window
                    build_redraw(view);
                end
                drive_sample(v, r == 1);
            end
            if (busy) abort_run("vector record too short to complete the capture");
            wait_idle();
            @(negedge clk);
            check("cap_busy", 16'(cap_busy), 16'(busy));

            void'($fscanf(fd, "%d", n));
            limit += 50 * n;
            for (int i = 0; i < n; i++) begin
                void'($fscanf(fd, "%d", act));
                if (act == 3) begin   // during a running redraw
                    while (!(render_busy && cmd_cnt >= 2)) @(negedge clk);
                end else begin
                    wait_idle();
                end
                if (act == 2 && view >= 5) begin
                    view -= 5;
                    build_redraw(view);
                end else if (act != 2 && view < 60) begin
                    view += 5;
                    build_redraw(view);
                end
                pulse_scroll(act != 2);
            end
            wait_idle();
        end
        $fclose(fd);

        if (exp_q.size() == 0 && exp_counts.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            abort_run("expected redraws were never issued by the DUT");
        end
    end

endmodule

// ==== testbench/scope_vectors.txt ====
# record: rate(0 ext rise, 1 ext fall) mode0..mode4 pos nsamp, then nsamp hex samples
# then nact and actions (1 right, 2 left, 3 right during a redraw)
0 0 0 0 0 0 0 117
00 01 03 07 0f 1f 1e 1c 18 10 00 15 0a 15 0a 1b 04 1b 04 11 0e 11 0e 13 0c
0c 13 13 02 05 08 17 1d 06 09 14 19 0b 0d 1a 12 16 1f 00 1f 00 0f 10 07 18
03 1c 01 1e 11 11 11 0e 0e 0e 04 04 1b 1b 15 0a 05 14 09 12 06 0c 18 11 03
07 0e 1c 19 13 07 0f 1e 1d 1b 17 0f 1f 1f 00 00 0a 0a 15 15 1a 0d 16 0b 05
02 01 10 08 04 02 01 1f 1e 1f 1e 1f 1e 00 0b 16 0c
0
0 4 5 1 2 0 1 64
01 0a 07 0a 06 12 05 0b 1c 03 19 0e 04 15 08 1b 00 1f 0d 06 13 09 16 02 11
1a 0c 07 18 05 1e 0b 14 01 0f 10 09 1d 06 17 03 12 0e 19 04 1b 0a 15 00 1c
0d 13 08 16 02 1f 05 0b 1a 0e 11 07 03 06
0
0 0 0 0 0 3 2 7
00 00 10 1f 0e 15 0a
15 2 1 1 1 1 1 1 1 1 1 1 1 1 1 2
1 0 0 0 0 0 2 5
1b 04 1f 00 0e
3 2 1 3

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arstn_sync
);

    initial begin
        clk        = 1'b0;
        arstn_sync = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial begin
        repeat (4) @(posedge clk);
        #1 arstn_sync = 1'b1;
    end

endmodule
